// ==== front_macros.svh ====
`ifndef FRONT_MACROS_SVH
`define FRONT_MACROS_SVH

// Instructions carried by one fetch line
`define FRONT_WAYS 2

// Address width
`define FRONT_XLEN 32

// Instruction width
`define FRONT_INST_W 32

// Memory line width, ways times instruction width
`define FRONT_LINE_W 64

// Slots in the fetch buffer, room for two lines
`define FRONT_BUF_DEPTH 4

// Instruction held by an empty slot
`define FRONT_NOP 32'h13

`endif

// ==== front_types_pkg.sv ====
`default_nettype none

`include "front_macros.svh"

package front_types_pkg;

	// One fetch buffer entry
	// Valid bit on top, then pc, then instruction word
	typedef struct packed {
		logic                     valid;
		logic [`FRONT_XLEN-1:0]   pc;
		logic [`FRONT_INST_W-1:0] inst;
	} inst_slot_t;

	// One memory line
	// Way 0 sits in the low word
	typedef logic [`FRONT_LINE_W-1:0] line_t;

	// Instructions taken by dispatch in one cycle
	typedef logic [1:0] disp_count_t;

endpackage

`default_nettype wire

// ==== front_bus_pkg.sv ====
`default_nettype none

package front_bus_pkg;

	// Memory command on the shared port
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_t;

	// Arbiter states
	// REQ holds mem_req up, REL waits for mem_ack to fall
	typedef enum logic [2:0] {
		ARB_IDLE     = 3'h0,
		ARB_DATA_REQ = 3'h1,
		ARB_DATA_REL = 3'h2,
		ARB_INST_REQ = 3'h3,
		ARB_INST_REL = 3'h4
	} arb_state_t;

endpackage

`default_nettype wire

// ==== bus_arbiter_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_macros.svh"

module bus_arbiter_fsm (
	input  wire logic                     clock,
	input  wire logic                     rst_n,
	input  wire logic                     flush,
	input  wire logic [`FRONT_XLEN-1:0]   fetch_pc,
	input  wire logic                     line_room,
	input  wire logic                     data_req,
	input  front_bus_pkg::bus_cmd_t       data_cmd,
	input  wire logic [`FRONT_XLEN-1:0]   data_addr,
	input  front_types_pkg::line_t        data_wdata,
	input  wire logic                     mem_ack,
	input  front_types_pkg::line_t        mem_rdata,
	output logic                          data_ack,
	output front_types_pkg::line_t        data_rdata,
	output logic                          mem_req,
	output front_bus_pkg::bus_cmd_t       mem_cmd,
	output logic [`FRONT_XLEN-1:0]        mem_addr,
	output front_types_pkg::line_t        mem_wdata,
	output logic                          line_valid,
	output logic [`FRONT_XLEN-1:0]        line_pc,
	output front_types_pkg::line_t        line_data
);

	// Byte offset bits inside one line
	localparam int OFS = $clog2(`FRONT_WAYS * 4);

	front_bus_pkg::arb_state_t state, state_nxt;
	logic                      cancel;
	logic                      start_data;
	logic                      start_inst;

	// Request fields, frozen for the whole handshake
	front_bus_pkg::bus_cmd_t   cmd_q;
	logic [`FRONT_XLEN-1:0]    addr_q;
	front_types_pkg::line_t    wdata_q;
	logic [`FRONT_XLEN-1:0]    inst_pc_q;
	front_types_pkg::line_t    rdata_q;

	////////////////////////////////////////
	// Request selection
	////////////////////////////////////////

	// Retire traffic beats fetch
	assign start_data = (state == front_bus_pkg::ARB_IDLE) && data_req;
	// No fetch on a flush edge, pc and buffer are both being replaced
	assign start_inst = (state == front_bus_pkg::ARB_IDLE) && !data_req && line_room && !flush;

	always_comb begin
		state_nxt = state;
		case (state)
			front_bus_pkg::ARB_IDLE: begin
				if (start_data)
					state_nxt = front_bus_pkg::ARB_DATA_REQ;
				else if (start_inst)
					state_nxt = front_bus_pkg::ARB_INST_REQ;
			end
			front_bus_pkg::ARB_DATA_REQ: begin
				if (mem_ack)
					state_nxt = front_bus_pkg::ARB_DATA_REL;
			end
			// Both sides must release before the port is free again
			front_bus_pkg::ARB_DATA_REL: begin
				if (!mem_ack && !data_req)
					state_nxt = front_bus_pkg::ARB_IDLE;
			end
			front_bus_pkg::ARB_INST_REQ: begin
				if (mem_ack)
					state_nxt = front_bus_pkg::ARB_INST_REL;
			end
			front_bus_pkg::ARB_INST_REL: begin
				if (!mem_ack)
					state_nxt = front_bus_pkg::ARB_IDLE;
			end
			default: state_nxt = front_bus_pkg::ARB_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			state <= front_bus_pkg::ARB_IDLE;
		else
			state <= state_nxt;
	end

	// Line in flight is dropped once a flush hits it
	always_ff @(posedge clock) begin
		if (!rst_n)
			cancel <= 1'b0;
		else if (state == front_bus_pkg::ARB_IDLE)
			cancel <= 1'b0;
		else if (flush && (state == front_bus_pkg::ARB_INST_REQ ||
				state == front_bus_pkg::ARB_INST_REL))
			cancel <= 1'b1;
	end

	////////////////////////////////////////
	// Bus fields
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (start_data) begin
			cmd_q   <= data_cmd;
			addr_q  <= data_addr;
			wdata_q <= data_wdata;
		end else if (start_inst) begin
			cmd_q     <= front_bus_pkg::BUS_LOAD;
			// Memory sees the line base, buffer keeps the exact pc
			addr_q    <= {fetch_pc[`FRONT_XLEN-1:OFS], {OFS{1'b0}}};
			wdata_q   <= '0;
			inst_pc_q <= fetch_pc;
		end
		// Load data held for retire until data_ack drops
		if (state == front_bus_pkg::ARB_DATA_REQ && mem_ack)
			rdata_q <= mem_rdata;
	end

	assign mem_req   = (state == front_bus_pkg::ARB_DATA_REQ) ||
			(state == front_bus_pkg::ARB_INST_REQ);
	assign mem_cmd   = mem_req ? cmd_q : front_bus_pkg::BUS_NONE;
	assign mem_addr  = addr_q;
	assign mem_wdata = wdata_q;

	assign data_ack   = (state == front_bus_pkg::ARB_DATA_REL);
	assign data_rdata = rdata_q;

	// One-cycle line pulse on the ack edge
	assign line_valid = (state == front_bus_pkg::ARB_INST_REQ) && mem_ack && !cancel && !flush;
	assign line_pc    = inst_pc_q;
	assign line_data  = mem_rdata;

	// Memory releases ack before the next request goes out
	a_req_after_release: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(mem_req) |-> !mem_ack)
		else $error("mem_req raised while mem_ack still high");

	// Retire keeps its request up until acknowledged
	a_data_req_held: assert property (@(posedge clock) disable iff (!rst_n)
		$fell(data_req) |-> data_ack)
		else $error("data_req dropped before data_ack");

endmodule

`default_nettype wire

// ==== pc_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_macros.svh"

module pc_counter (
	input  wire logic                   clock,
	input  wire logic                   rst_n,
	input  wire logic                   flush,
	input  wire logic [`FRONT_XLEN-1:0] target_pc,
	input  wire logic                   line_valid,
	output logic [`FRONT_XLEN-1:0]      fetch_pc
);

	localparam int OFS        = $clog2(`FRONT_WAYS * 4);
	localparam int XLEN       = `FRONT_XLEN;
	localparam int LINE_BYTES = `FRONT_WAYS * 4;

	logic [`FRONT_XLEN-1:0] pc_q;
	logic [`FRONT_XLEN-1:0] line_base;

	// Start of the line being fetched
	assign line_base = {pc_q[`FRONT_XLEN-1:OFS], {OFS{1'b0}}};

	// Redirect keeps the in-line offset
	// so the buffer can mask the words ahead of the target
	always_ff @(posedge clock) begin
		if (!rst_n)
			pc_q <= '0;
		else if (flush)
			pc_q <= target_pc;
		else if (line_valid)
			pc_q <= line_base + XLEN'(LINE_BYTES);
	end

	assign fetch_pc = pc_q;

	// Fetch address stays on an instruction boundary
	a_word_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		fetch_pc[1:0] == 2'b00)
		else $error("fetch_pc not word aligned");

endmodule

`default_nettype wire

// ==== fetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_macros.svh"

module fetch_buffer (
	input  wire logic                                       clock,
	input  wire logic                                       rst_n,
	input  wire logic                                       flush,
	input  wire logic                                       line_valid,
	input  wire logic [`FRONT_XLEN-1:0]                     line_pc,
	input  front_types_pkg::line_t                          line_data,
	input  front_types_pkg::disp_count_t                    dispatch_count,
	output logic                                            line_room,
	output front_types_pkg::inst_slot_t [`FRONT_WAYS-1:0]   head
);

	localparam int DEPTH  = `FRONT_BUF_DEPTH;
	localparam int WAYS   = `FRONT_WAYS;
	localparam int XLEN   = `FRONT_XLEN;
	localparam int INST_W = `FRONT_INST_W;
	localparam int OFS    = $clog2(WAYS * 4);
	localparam int CW     = $clog2(DEPTH + 1);

	localparam front_types_pkg::inst_slot_t EMPTY_SLOT = '{
		valid: 1'b0,
		pc:    '0,
		inst:  `FRONT_NOP
	};

	front_types_pkg::inst_slot_t [DEPTH-1:0] slots;
	front_types_pkg::inst_slot_t [DEPTH-1:0] nxt;
	logic [CW-1:0]                           count;
	logic [CW-1:0]                           fill;
	logic [XLEN-1:0]                         line_base;
	logic [OFS-3:0]                          first_way;

	assign line_base = {line_pc[XLEN-1:OFS], {OFS{1'b0}}};
	// Words ahead of a redirect target are skipped
	assign first_way = line_pc[OFS-1:2];

	////////////////////////////////////////
	// Shift and refill
	////////////////////////////////////////

	always_comb begin
		// Drop dispatched slots off the head
		for (int i = 0; i < DEPTH; i++) begin
			if (i + int'(dispatch_count) < DEPTH)
				nxt[i] = slots[i + int'(dispatch_count)];
			else
				nxt[i] = EMPTY_SLOT;
		end
		// Append arriving words behind the survivors
		fill = count - CW'(dispatch_count);
		for (int w = 0; w < WAYS; w++) begin
			if (line_valid && w >= int'(first_way) && int'(fill) < DEPTH) begin
				nxt[fill] = '{
					valid: 1'b1,
					pc:    line_base + XLEN'(4 * w),
					inst:  line_data[w*INST_W +: INST_W]
				};
				fill = fill + 1'b1;
			end
		end
	end

	// Flush beats dispatch and refill
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			for (int i = 0; i < DEPTH; i++)
				slots[i] <= EMPTY_SLOT;
			count <= '0;
		end else begin
			slots <= nxt;
			count <= fill;
		end
	end

	// Arbiter samples this only while idle
	// so a line in flight is already counted once it lands
	assign line_room = (count <= CW'(DEPTH - WAYS));

	assign head = slots[WAYS-1:0];

	// Dispatch may only take what the head shows
	a_disp_le_valid: assert property (@(posedge clock) disable iff (!rst_n)
		int'(dispatch_count) <= ((int'(count) < WAYS) ? int'(count) : WAYS))
		else $error("dispatch_count exceeds valid head slots");

endmodule

`default_nettype wire

// ==== fetch_front.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_macros.svh"

module fetch_front (
	input  wire logic                                      clock,
	input  wire logic                                      rst_n,
	input  wire logic                                      flush,
	input  wire logic [`FRONT_XLEN-1:0]                    target_pc,
	input  front_types_pkg::disp_count_t                   dispatch_count,
	output logic [`FRONT_WAYS-1:0]                         slot_valid,
	output logic [`FRONT_WAYS-1:0][`FRONT_XLEN-1:0]        slot_pc,
	output logic [`FRONT_WAYS-1:0][`FRONT_INST_W-1:0]      slot_inst,
	input  wire logic                                      data_req,
	input  front_bus_pkg::bus_cmd_t                        data_cmd,
	input  wire logic [`FRONT_XLEN-1:0]                    data_addr,
	input  front_types_pkg::line_t                         data_wdata,
	output logic                                           data_ack,
	output front_types_pkg::line_t                         data_rdata,
	output logic                                           mem_req,
	output front_bus_pkg::bus_cmd_t                        mem_cmd,
	output logic [`FRONT_XLEN-1:0]                         mem_addr,
	output front_types_pkg::line_t                         mem_wdata,
	input  wire logic                                      mem_ack,
	input  front_types_pkg::line_t                         mem_rdata
);

	logic [`FRONT_XLEN-1:0]                             fetch_pc;
	logic                                               line_room;
	logic                                               line_valid;
	logic [`FRONT_XLEN-1:0]                             line_pc;
	front_types_pkg::line_t                             line_data;
	front_types_pkg::inst_slot_t [`FRONT_WAYS-1:0]      head;

	// Fetch address
	pc_counter u_pc_counter (
		.clock      (clock),
		.rst_n      (rst_n),
		.flush      (flush),
		.target_pc  (target_pc),
		.line_valid (line_valid),
		.fetch_pc   (fetch_pc)
	);

	// Shared memory port
	bus_arbiter_fsm u_bus_arbiter_fsm (
		.clock      (clock),
		.rst_n      (rst_n),
		.flush      (flush),
		.fetch_pc   (fetch_pc),
		.line_room  (line_room),
		.data_req   (data_req),
		.data_cmd   (data_cmd),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.mem_ack    (mem_ack),
		.mem_rdata  (mem_rdata),
		.data_ack   (data_ack),
		.data_rdata (data_rdata),
		.mem_req    (mem_req),
		.mem_cmd    (mem_cmd),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.line_valid (line_valid),
		.line_pc    (line_pc),
		.line_data  (line_data)
	);

	// Instruction queue toward dispatch
	fetch_buffer u_fetch_buffer (
		.clock          (clock),
		.rst_n          (rst_n),
		.flush          (flush),
		.line_valid     (line_valid),
		.line_pc        (line_pc),
		.line_data      (line_data),
		.dispatch_count (dispatch_count),
		.line_room      (line_room),
		.head           (head)
	);

	// Head slots out as plain ports
	always_comb begin
		for (int i = 0; i < `FRONT_WAYS; i++) begin
			slot_valid[i] = head[i].valid;
			slot_pc[i]    = head[i].pc;
			slot_inst[i]  = head[i].inst;
		end
	end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_macros.svh"

module tb_mem_model (
	input  wire logic                   clock,
	input  wire logic                   mem_req,
	input  front_bus_pkg::bus_cmd_t     mem_cmd,
	input  wire logic [`FRONT_XLEN-1:0] mem_addr,
	input  front_types_pkg::line_t      mem_wdata,
	output logic                        mem_ack,
	output front_types_pkg::line_t      mem_rdata
);

	// Code word at byte address a is a XOR this key
	localparam logic [`FRONT_XLEN-1:0] INST_KEY = 32'hA500_0000;

	// Top address bit set selects data space, the rest is code
	front_types_pkg::line_t data_mem [logic [`FRONT_XLEN-1:0]];
	int                     seed;
	int                     delay;

	////////////////////////////////////////
	// Four-phase responder
	////////////////////////////////////////

	initial begin
		seed      = 32'h51f1;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clock);
			if (mem_req === 1'b1) begin
				// 0 to 3 cycles of latency
				delay = $random(seed) & 3;
				repeat (delay) @(negedge clock);
				@(posedge clock);
				#2;
				if (mem_addr[`FRONT_XLEN-1]) begin
					if (mem_cmd == front_bus_pkg::BUS_STORE)
						data_mem[mem_addr] = mem_wdata;
					else if (data_mem.exists(mem_addr))
						mem_rdata = data_mem[mem_addr];
					else
						mem_rdata = '0;
				end else begin
					// Way 0 in the low word
					mem_rdata = {(mem_addr + 32'd4) ^ INST_KEY, mem_addr ^ INST_KEY};
				end
				mem_ack = 1'b1;
				// Ack stays up until the request drops
				do begin
					@(negedge clock);
				end while (mem_req);
				@(posedge clock);
				#2;
				mem_ack = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_fetch_front.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "front_macros.svh"

module tb_fetch_front;

	localparam int ROWS = 13;
	localparam logic [`FRONT_XLEN-1:0] INST_KEY = 32'hA500_0000;

	// One table row
	// fmode 0 none, 1 flush at once, 2 flush with a fetch in flight
	typedef struct packed {
		front_types_pkg::disp_count_t disp;
		logic [7:0]                   reps;
		logic [1:0]                   fmode;
		logic [`FRONT_XLEN-1:0]       target;
		front_bus_pkg::bus_cmd_t      cmd;
		logic [`FRONT_XLEN-1:0]       addr;
		front_types_pkg::line_t       wdata;
	} row_t;

	logic                                      clock;
	logic                                      rst_n;
	logic                                      flush;
	logic [`FRONT_XLEN-1:0]                    target_pc;
	front_types_pkg::disp_count_t              dispatch_count;
	logic [`FRONT_WAYS-1:0]                    slot_valid;
	logic [`FRONT_WAYS-1:0][`FRONT_XLEN-1:0]   slot_pc;
	logic [`FRONT_WAYS-1:0][`FRONT_INST_W-1:0] slot_inst;
	logic                                      data_req;
	front_bus_pkg::bus_cmd_t                   data_cmd;
	logic [`FRONT_XLEN-1:0]                    data_addr;
	front_types_pkg::line_t                    data_wdata;
	logic                                      data_ack;
	front_types_pkg::line_t                    data_rdata;
	logic                                      mem_req;
	front_bus_pkg::bus_cmd_t                   mem_cmd;
	logic [`FRONT_XLEN-1:0]                    mem_addr;
	front_types_pkg::line_t                    mem_wdata;
	logic                                      mem_ack;
	front_types_pkg::line_t                    mem_rdata;

	row_t                   rows [ROWS];
	string                  names [ROWS];
	int                     n_rows;
	// Next pc dispatch should hand out
	logic [`FRONT_XLEN-1:0] exp_pc;
	// Lines stored through the data port
	front_types_pkg::line_t shadow [logic [`FRONT_XLEN-1:0]];

	fetch_front u_fetch_front (
		.clock(clock), .rst_n(rst_n), .flush(flush), .target_pc(target_pc),
		.dispatch_count(dispatch_count), .slot_valid(slot_valid), .slot_pc(slot_pc),
		.slot_inst(slot_inst), .data_req(data_req), .data_cmd(data_cmd),
		.data_addr(data_addr), .data_wdata(data_wdata), .data_ack(data_ack),
		.data_rdata(data_rdata), .mem_req(mem_req), .mem_cmd(mem_cmd),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	tb_mem_model u_mem_model (
		.clock(clock), .mem_req(mem_req), .mem_cmd(mem_cmd), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	// 40 ns period
	always #20 clock = ~clock;

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_slot(input string name, input front_types_pkg::inst_slot_t exp,
			input front_types_pkg::inst_slot_t act);
		if (act !== exp)
			stop_on_error($sformatf("FAILED %s expected v=%0b pc=%h inst=%h %s",
				name, exp.valid, exp.pc, exp.inst,
				$sformatf("actual v=%0b pc=%h inst=%h", act.valid, act.pc, act.inst)));
	endtask

	task automatic check_line(input string name, input front_types_pkg::line_t exp,
			input front_types_pkg::line_t act);
		if (act !== exp)
			stop_on_error($sformatf("FAILED %s expected %h actual %h", name, exp, act));
	endtask

	function automatic int head_valid();
		int n;
		n = 0;
		for (int i = 0; i < `FRONT_WAYS; i++)
			n += int'(slot_valid[i]);
		return n;
	endfunction

	////////////////////////////////////////
	// Row actions, all start and end 2 ns after an edge
	////////////////////////////////////////

	task automatic take(input string name, input front_types_pkg::disp_count_t n);
		front_types_pkg::inst_slot_t got;
		front_types_pkg::inst_slot_t exp;
		while (head_valid() < int'(n)) begin
			@(posedge clock);
			#2;
		end
		for (int i = 0; i < int'(n); i++) begin
			got = '{valid: slot_valid[i], pc: slot_pc[i], inst: slot_inst[i]};
			exp = '{valid: 1'b1, pc: exp_pc, inst: exp_pc ^ INST_KEY};
			check_slot(name, exp, got);
			exp_pc = exp_pc + 32'd4;
		end
		dispatch_count = n;
		@(posedge clock);
		#2;
		dispatch_count = '0;
	endtask

	// Long holds fill the buffer, so the port must go quiet near the end
	task automatic hold(input string name, input int cycles);
		for (int c = 0; c < cycles; c++) begin
			if (cycles >= 16 && c >= cycles - 4 && mem_req)
				stop_on_error($sformatf("%s: mem_req raised while the fetch buffer was full",
					name));
			@(posedge clock);
			#2;
		end
	endtask

	task automatic redirect(input logic wait_fetch, input logic [`FRONT_XLEN-1:0] target);
		// Catch an instruction fetch mid handshake
		while (wait_fetch && !mem_req) begin
			@(posedge clock);
			#2;
		end
		flush     = 1'b1;
		target_pc = target;
		@(posedge clock);
		#2;
		flush  = 1'b0;
		exp_pc = target;
	endtask

	task automatic data_access(input string name, input front_bus_pkg::bus_cmd_t cmd,
			input logic [`FRONT_XLEN-1:0] addr, input front_types_pkg::line_t wdata);
		front_types_pkg::line_t exp;
		data_req   = 1'b1;
		data_cmd   = cmd;
		data_addr  = addr;
		data_wdata = wdata;
		while (!data_ack) begin
			@(posedge clock);
			#2;
		end
		if (cmd == front_bus_pkg::BUS_STORE) begin
			shadow[addr] = wdata;
		end else begin
			exp = shadow.exists(addr) ? shadow[addr] : '0;
			check_line(name, exp, data_rdata);
		end
		data_req = 1'b0;
		while (data_ack) begin
			@(posedge clock);
			#2;
		end
	endtask

	task automatic add_row(input string name, input int disp, input int reps, input int fmode,
			input logic [`FRONT_XLEN-1:0] target, input front_bus_pkg::bus_cmd_t cmd,
			input logic [`FRONT_XLEN-1:0] addr, input front_types_pkg::line_t wdata);
		names[n_rows]       = name;
		rows[n_rows].disp   = front_types_pkg::disp_count_t'(disp);
		rows[n_rows].reps   = 8'(reps);
		rows[n_rows].fmode  = 2'(fmode);
		rows[n_rows].target = target;
		rows[n_rows].cmd    = cmd;
		rows[n_rows].addr   = addr;
		rows[n_rows].wdata  = wdata;
		n_rows++;
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		clock          = 1'b0;
		rst_n          = 1'b0;
		flush          = 1'b0;
		target_pc      = '0;
		dispatch_count = '0;
		data_req       = 1'b0;
		data_cmd       = front_bus_pkg::BUS_NONE;
		data_addr      = '0;
		data_wdata     = '0;
		exp_pc         = '0;
		n_rows         = 0;
		// name, dispatch, repeats, flush mode, target, command, address, data
		add_row("reset_seq_a", 2, 2, 0, 32'h0, front_bus_pkg::BUS_NONE, 32'h0, 64'h0);
		add_row("reset_seq_b", 1, 1, 0, 32'h0, front_bus_pkg::BUS_NONE, 32'h0, 64'h0);
		add_row("back_pressure", 0, 20, 0, 32'h0, front_bus_pkg::BUS_NONE, 32'h0, 64'h0);
		add_row("bp_resume", 2, 2, 0, 32'h0, front_bus_pkg::BUS_NONE, 32'h0, 64'h0);
		add_row("partial_1", 1, 3, 0, 32'h0, front_bus_pkg::BUS_NONE, 32'h0, 64'h0);
		add_row("partial_0", 0, 3, 0, 32'h0, front_bus_pkg::BUS_NONE, 32'h0, 64'h0);
		add_row("partial_2", 2, 3, 0, 32'h0, front_bus_pkg::BUS_NONE, 32'h0, 64'h0);
		add_row("flush_mid", 1, 3, 1, 32'h104, front_bus_pkg::BUS_NONE, 32'h0, 64'h0);
		add_row("drain", 2, 2, 0, 32'h0, front_bus_pkg::BUS_NONE, 32'h0, 64'h0);
		add_row("flush_in_flight", 2, 2, 2, 32'h20c, front_bus_pkg::BUS_NONE, 32'h0, 64'h0);
		add_row("store", 1, 1, 0, 32'h0, front_bus_pkg::BUS_STORE, 32'h8000_0040,
			64'h0123_4567_89ab_cdef);
		add_row("load_back", 2, 1, 0, 32'h0, front_bus_pkg::BUS_LOAD, 32'h8000_0040, 64'h0);
		add_row("load_empty", 1, 2, 0, 32'h0, front_bus_pkg::BUS_LOAD, 32'h8000_0080, 64'h0);

		repeat (8) @(posedge clock);
		#2;
		rst_n = 1'b1;

		for (int r = 0; r < ROWS; r++) begin
			if (rows[r].fmode != 2'd0)
				redirect(rows[r].fmode == 2'd2, rows[r].target);
			if (rows[r].cmd != front_bus_pkg::BUS_NONE)
				data_access(names[r], rows[r].cmd, rows[r].addr, rows[r].wdata);
			if (rows[r].disp == '0) begin
				hold(names[r], int'(rows[r].reps));
			end else begin
				for (int k = 0; k < int'(rows[r].reps); k++)
					take(names[r], rows[r].disp);
			end
		end

		$display("** PASS **");
		$finish;
	end

	// Watchdog, 40 cycles per row
	initial begin
		front_bus_pkg::arb_state_t stuck;
		#(ROWS * 40 * 40);
		stuck = u_fetch_front.u_bus_arbiter_fsm.state;
		stop_on_error($sformatf("Timeout: run did not finish, arbiter in state %s",
			stuck.name()));
	end

endmodule

`default_nettype wire

// ==== fetch_front.f ====
+incdir+.
front_types_pkg.sv
front_bus_pkg.sv
bus_arbiter_fsm.sv
pc_counter.sv
fetch_buffer.sv
fetch_front.sv
tb_mem_model.sv
tb_fetch_front.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_fetch_front
FILELIST  ?= fetch_front.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
